/* verilog/cpu_pkg.sv */
package cpu_pkg;

    localparam int DATA_W    = 16;
    localparam int ADDR_W    = 8;
    localparam int MEM_DEPTH = 256;
    localparam int REG_SEL_W = 4;
    localparam int NUM_REGS  = 16;

    // opcodes in ir[15:12]
    localparam logic [3:0] OP_SYS    = 4'b0000; // halt, write
    localparam logic [3:0] OP_SETN   = 4'b0001;
    localparam logic [3:0] OP_LOADN  = 4'b0010;
    localparam logic [3:0] OP_STOREN = 4'b0011;
    localparam logic [3:0] OP_ADDN   = 4'b0101;
    localparam logic [3:0] OP_ADD    = 4'b0110; // also nop and copy
    localparam logic [3:0] OP_SUB    = 4'b0111; // also neg
    localparam logic [3:0] OP_JUMPN  = 4'b1011;
    localparam logic [1:0] OP_JCOND  = 2'b11;   // matched against ir[15:14]

    // OP_SYS sub-codes in ir[1:0]
    localparam logic [1:0] SYS_HALT  = 2'b00;
    localparam logic [1:0] SYS_WRITE = 2'b10;

    // jump conditions in ir[13:12]
    localparam logic [1:0] COND_EQZ = 2'b00;
    localparam logic [1:0] COND_NEZ = 2'b01;
    localparam logic [1:0] COND_GTZ = 2'b10;
    localparam logic [1:0] COND_LTZ = 2'b11;

    typedef logic [2:0] step_t;

    typedef enum logic [2:0] {
        BUS_NONE = 3'd0, // bus reads zero
        BUS_PC   = 3'd1,
        BUS_MEM  = 3'd2,
        BUS_REG  = 3'd3,
        BUS_ALU  = 3'd4,
        BUS_IMM  = 3'd5
    } bus_src_t;

    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1  // tmp0 - tmp1
    } alu_op_t;

endpackage

/* verilog/micro_sequencer.sv */
`timescale 1ns/100ps

module micro_sequencer
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 writing_program,
    input  logic [DATA_W-1:0]    bus,
    input  logic                 flags_zero,
    input  logic                 flags_sign,
    output bus_src_t             bus_src,
    output logic [DATA_W-1:0]    imm_data,
    output logic                 mar_in,
    output logic                 mem_we,
    output logic                 pc_inc,
    output logic                 pc_jump,
    output logic                 tmp0_in,
    output logic                 tmp1_in,
    output logic                 flags_in,
    output logic                 reg_we,
    output logic [REG_SEL_W-1:0] reg_sel,
    output alu_op_t              alu_op,
    output logic                 out_valid,
    output logic [DATA_W-1:0]    out_data,
    output logic                 halted
);
    logic [DATA_W-1:0] ir;
    step_t             step;
    logic              run;
    logic              last;      // final step of the current instruction
    logic              ir_load;
    logic              out_load;
    logic              halt_set;
    logic              imm_zero;
    logic              jump_take;

    wire [3:0]           opcode = ir[15:12];
    wire [1:0]           cond   = ir[13:12];
    wire [REG_SEL_W-1:0] rx     = ir[11:8];
    wire [REG_SEL_W-1:0] ry     = ir[7:4];
    wire [REG_SEL_W-1:0] rz     = ir[3:0];

    assign run = !writing_program && !halted;

    assign imm_data = imm_zero ? '0 : {{(DATA_W-ADDR_W){1'b0}}, ir[ADDR_W-1:0]};

    always_comb begin
        case (cond)
            COND_EQZ: jump_take = flags_zero;
            COND_NEZ: jump_take = !flags_zero;
            COND_GTZ: jump_take = !flags_zero && !flags_sign;
            default:  jump_take = flags_sign;   // ltz
        endcase
    end

    always_comb begin
        bus_src  = BUS_NONE;
        mar_in   = 1'b0;
        mem_we   = 1'b0;
        pc_inc   = 1'b0;
        pc_jump  = 1'b0;
        tmp0_in  = 1'b0;
        tmp1_in  = 1'b0;
        flags_in = 1'b0;
        reg_we   = 1'b0;
        reg_sel  = rx;
        alu_op   = ALU_ADD;
        ir_load  = 1'b0;
        out_load = 1'b0;
        halt_set = 1'b0;
        imm_zero = 1'b0;
        last     = 1'b0;
        if (run) begin
            if (step == 3'd0) begin            // fetch: pc to mar
                bus_src = BUS_PC;
                mar_in  = 1'b1;
            end else if (step == 3'd1) begin   // fetch: memory to ir
                bus_src = BUS_MEM;
                ir_load = 1'b1;
                pc_inc  = 1'b1;
            end else if (ir[15:14] == OP_JCOND) begin
                case (step)
                    3'd2: begin bus_src = BUS_REG; tmp0_in = 1'b1; end
                    3'd3: begin bus_src = BUS_IMM; imm_zero = 1'b1; tmp1_in = 1'b1; end
                    3'd4: begin alu_op = ALU_SUB; flags_in = 1'b1; end // rx - 0
                    default: begin
                        bus_src = BUS_IMM;
                        pc_jump = jump_take;
                        last    = 1'b1;
                    end
                endcase
            end else begin
                case (opcode)
                    OP_SYS: begin
                        halt_set = (ir[1:0] == SYS_HALT);
                        if (ir[1:0] == SYS_WRITE) begin
                            bus_src  = BUS_REG;
                            out_load = 1'b1;
                        end
                        last = 1'b1;
                    end
                    OP_SETN: begin
                        bus_src = BUS_IMM;
                        reg_we  = 1'b1;
                        last    = 1'b1;
                    end
                    OP_LOADN, OP_STOREN: begin
                        if (step == 3'd2) begin    // address to mar
                            bus_src = BUS_IMM;
                            mar_in  = 1'b1;
                        end else begin
                            bus_src = (opcode == OP_LOADN) ? BUS_MEM : BUS_REG;
                            reg_we  = (opcode == OP_LOADN);
                            mem_we  = (opcode == OP_STOREN);
                            last    = 1'b1;
                        end
                    end
                    OP_ADDN, OP_ADD, OP_SUB: begin
                        case (step)
                            3'd2: begin
                                bus_src = (opcode == OP_ADDN) ? BUS_IMM : BUS_REG;
                                reg_sel = ry;
                                tmp0_in = 1'b1;
                            end
                            3'd3: begin
                                bus_src = BUS_REG;
                                reg_sel = (opcode == OP_ADDN) ? rx : rz;
                                tmp1_in = 1'b1;
                            end
                            default: begin
                                bus_src = BUS_ALU;
                                alu_op  = (opcode == OP_SUB) ? ALU_SUB : ALU_ADD;
                                reg_we  = 1'b1;
                                last    = 1'b1;
                            end
                        endcase
                    end
                    OP_JUMPN: begin
                        bus_src = BUS_IMM;
                        pc_jump = 1'b1;
                        last    = 1'b1;
                    end
                    default: last = 1'b1;          // unused codes act as nop
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step      <= '0;
            ir        <= '0;
            out_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            out_valid <= out_load;                // one-cycle pulse
            if (halt_set)
                halted <= 1'b1;                   // sticky until rst
            if (ir_load)
                ir <= bus;
            if (writing_program)
                step <= '0;
            else if (run)
                step <= last ? step_t'(0) : step + step_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (out_load)
            out_data <= bus;
    end

endmodule

/* verilog/program_counter.sv */
`timescale 1ns/100ps

module program_counter
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              pc_inc,
    input  logic              pc_jump,
    input  logic [DATA_W-1:0] bus,
    output logic [ADDR_W-1:0] pc
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_jump) begin
            pc <= bus[ADDR_W-1:0];         // target is the low byte
        end else if (pc_inc) begin
            pc <= pc + ADDR_W'(1);         // wraps past the last word
        end
    end

endmodule

/* verilog/register_file.sv */
`timescale 1ns/100ps

module register_file
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [REG_SEL_W-1:0] reg_sel,
    input  logic                 reg_we,
    input  logic [DATA_W-1:0]    bus,
    output logic [DATA_W-1:0]    rdata
);
    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we && reg_sel != '0) begin   // r0 is read-only
            regs[reg_sel] <= bus;
        end
    end

    // r0 reads zero, so add covers nop and copy
    assign rdata = (reg_sel == '0) ? '0 : regs[reg_sel];

endmodule

/* verilog/alu_unit.sv */
`timescale 1ns/100ps

module alu_unit
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              tmp0_in,
    input  logic              tmp1_in,
    input  logic              flags_in,
    input  alu_op_t           alu_op,
    input  logic [DATA_W-1:0] bus,
    output logic [DATA_W-1:0] result,
    output logic              flags_zero,
    output logic              flags_sign
);
    logic [DATA_W-1:0] tmp0;
    logic [DATA_W-1:0] tmp1;

    // operand latches
    always_ff @(posedge clk) begin
        if (tmp0_in)
            tmp0 <= bus;
        if (tmp1_in)
            tmp1 <= bus;
    end

    always_comb begin
        case (alu_op)
            ALU_SUB: result = tmp0 - tmp1;   // modulo 2^16
            default: result = tmp0 + tmp1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags_zero <= 1'b0;
            flags_sign <= 1'b0;
        end else if (flags_in) begin
            flags_zero <= (result == '0);
            flags_sign <= result[DATA_W-1];
        end
    end

endmodule

/* verilog/program_memory.sv */
`timescale 1ns/100ps

module program_memory
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              writing_program,
    input  logic              prog_we,
    input  logic [ADDR_W-1:0] prog_addr,
    input  logic [DATA_W-1:0] prog_wdata,
    input  logic              mar_in,
    input  logic              mem_we,
    input  logic [DATA_W-1:0] bus,
    output logic [DATA_W-1:0] rdata
);
    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic [ADDR_W-1:0] mar;

    always_ff @(posedge clk) begin
        if (writing_program) begin
            if (prog_we)
                mem[prog_addr] <= prog_wdata;   // load port owns the array
        end else begin
            if (mar_in)
                mar <= bus[ADDR_W-1:0];
            if (mem_we)
                mem[mar] <= bus;
        end
    end

    assign rdata = mem[mar];    // async read from mar

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              writing_program,
    input  logic              prog_we,
    input  logic [ADDR_W-1:0] prog_addr,
    input  logic [DATA_W-1:0] prog_wdata,
    output logic              out_valid,
    output logic [DATA_W-1:0] out_data,
    output logic              halted
);
    logic [DATA_W-1:0]    bus;
    bus_src_t             bus_src;
    logic [DATA_W-1:0]    imm_data;
    logic                 mar_in;
    logic                 mem_we;
    logic                 pc_inc;
    logic                 pc_jump;
    logic                 tmp0_in;
    logic                 tmp1_in;
    logic                 flags_in;
    logic                 reg_we;
    logic [REG_SEL_W-1:0] reg_sel;
    alu_op_t              alu_op;
    logic                 flags_zero;
    logic                 flags_sign;
    logic [ADDR_W-1:0]    pc;
    logic [DATA_W-1:0]    mem_rdata;
    logic [DATA_W-1:0]    reg_rdata;
    logic [DATA_W-1:0]    alu_result;

    // single-driver bus in place of tri-state
    always_comb begin
        case (bus_src)
            BUS_PC:  bus = {{(DATA_W-ADDR_W){1'b0}}, pc};
            BUS_MEM: bus = mem_rdata;
            BUS_REG: bus = reg_rdata;
            BUS_ALU: bus = alu_result;
            BUS_IMM: bus = imm_data;
            default: bus = '0;
        endcase
    end

    micro_sequencer seq0 (
        .clk(clk), .rst(rst), .writing_program(writing_program), .bus(bus),
        .flags_zero(flags_zero), .flags_sign(flags_sign), .bus_src(bus_src),
        .imm_data(imm_data), .mar_in(mar_in), .mem_we(mem_we), .pc_inc(pc_inc),
        .pc_jump(pc_jump), .tmp0_in(tmp0_in), .tmp1_in(tmp1_in), .flags_in(flags_in),
        .reg_we(reg_we), .reg_sel(reg_sel), .alu_op(alu_op), .out_valid(out_valid),
        .out_data(out_data), .halted(halted)
    );

    program_counter pc0 (
        .clk(clk), .rst(rst), .pc_inc(pc_inc), .pc_jump(pc_jump), .bus(bus), .pc(pc)
    );

    register_file regs0 (
        .clk(clk), .rst(rst), .reg_sel(reg_sel), .reg_we(reg_we), .bus(bus),
        .rdata(reg_rdata)
    );

    alu_unit alu0 (
        .clk(clk), .rst(rst), .tmp0_in(tmp0_in), .tmp1_in(tmp1_in), .flags_in(flags_in),
        .alu_op(alu_op), .bus(bus), .result(alu_result), .flags_zero(flags_zero),
        .flags_sign(flags_sign)
    );

    program_memory mem0 (
        .clk(clk), .writing_program(writing_program), .prog_we(prog_we),
        .prog_addr(prog_addr), .prog_wdata(prog_wdata), .mar_in(mar_in),
        .mem_we(mem_we), .bus(bus), .rdata(mem_rdata)
    );

endmodule

/* sim/cpu_assert.sv */
`timescale 1ns/100ps

module cpu_assert (
    input logic clk,
    input logic rst,
    input logic writing_program,
    input logic mar_in,
    input logic mem_we,
    input logic pc_inc,
    input logic pc_jump,
    input logic tmp0_in,
    input logic tmp1_in,
    input logic flags_in,
    input logic reg_we,
    input logic halted
);
    int failures = 0;

    we_exclusive: assert property (@(posedge clk) disable iff (rst) !(reg_we && mem_we))
        else begin
            $error("reg_we and mem_we high in the same cycle");
            failures++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (rst) $fell(halted) |-> $past(rst))
        else begin
            $error("halted dropped without reset");
            failures++;
        end

    // core must sit idle while the loader owns memory
    idle_while_loading: assert property (@(posedge clk) writing_program |->
        !(mar_in || mem_we || pc_inc || pc_jump || tmp0_in || tmp1_in || flags_in || reg_we))
        else begin
            $error("strobe active while the program is loading");
            failures++;
        end

endmodule

bind micro_sequencer cpu_assert assert0 (.*);

/* sim/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb
    import cpu_pkg::*;
;
    localparam logic [7:0] DATA_BASE   = 8'hF0; // data words live at the top of memory
    localparam int         RUN_LIMIT   = 2000;  // cycles allowed before halt
    localparam int         HALT_WINDOW = 20;
    localparam int         STEP_LIMIT  = 1000;  // instructions in the reference run

    logic              clk = 1'b0;
    logic              rst;
    logic              writing_program;
    logic              prog_we;
    logic [ADDR_W-1:0] prog_addr;
    logic [DATA_W-1:0] prog_wdata;
    logic              out_valid;
    logic [DATA_W-1:0] out_data;
    logic              halted;

    logic [15:0] code_q[$];
    logic [15:0] data_q[$];
    logic [15:0] expected[$];
    logic [31:0] seed = 32'h756e;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    cpu_top dut0 (
        .clk(clk), .rst(rst), .writing_program(writing_program), .prog_we(prog_we),
        .prog_addr(prog_addr), .prog_wdata(prog_wdata), .out_valid(out_valid),
        .out_data(out_data), .halted(halted)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [15:0] rand16();
        seed = xorshift(seed);
        return seed[15:0];
    endfunction

    function automatic logic [15:0] enc_rrr(input logic [3:0] op, input logic [3:0] x,
                                            input logic [3:0] y, input logic [3:0] z);
        return {op, x, y, z};
    endfunction

    function automatic logic [15:0] enc_imm(input logic [3:0] op, input logic [3:0] x,
                                            input logic [7:0] imm);
        return {op, x, imm};
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // interprets code_q and data_q, fills the list of expected write values
    function automatic void run_reference();
        logic [15:0] mem [256];
        logic [15:0] r [16];
        logic [7:0]  pc;
        logic [15:0] ir;
        logic [15:0] wval;
        logic        wen;
        logic        zf;
        logic        sf;
        logic        take;
        expected.delete();
        foreach (mem[i]) mem[i] = '0;
        foreach (r[i]) r[i] = '0;
        foreach (code_q[i]) mem[i] = code_q[i];
        foreach (data_q[i]) mem[DATA_BASE + i] = data_q[i];
        pc = '0;
        zf = 1'b0;
        sf = 1'b0;
        for (int n = 0; n < STEP_LIMIT; n++) begin
            ir = mem[pc];
            pc = pc + 8'd1;
            wen = 1'b0;
            wval = '0;
            if (ir[15:14] == OP_JCOND) begin
                zf = (r[ir[11:8]] == 16'h0);   // rx minus zero
                sf = r[ir[11:8]][15];
                case (ir[13:12])
                    COND_EQZ: take = zf;
                    COND_NEZ: take = !zf;
                    COND_LTZ: take = sf;
                    default:  take = !zf && !sf;
                endcase
                if (take)
                    pc = ir[7:0];
            end else begin
                case (ir[15:12])
                    OP_SYS: begin
                        if (ir[1:0] == SYS_HALT)
                            return;
                        if (ir[1:0] == SYS_WRITE)
                            expected.push_back(r[ir[11:8]]);
                    end
                    OP_SETN: begin
                        wen = 1'b1;
                        wval = {8'h00, ir[7:0]};
                    end
                    OP_LOADN: begin
                        wen = 1'b1;
                        wval = mem[ir[7:0]];
                    end
                    OP_STOREN: mem[ir[7:0]] = r[ir[11:8]];
                    OP_ADDN: begin
                        wen = 1'b1;
                        wval = r[ir[11:8]] + {8'h00, ir[7:0]};
                    end
                    OP_ADD: begin
                        wen = 1'b1;
                        wval = r[ir[7:4]] + r[ir[3:0]];
                    end
                    OP_SUB: begin
                        wen = 1'b1;
                        wval = r[ir[7:4]] - r[ir[3:0]];
                    end
                    OP_JUMPN: pc = ir[7:0];
                    default: ;
                endcase
                if (wen && ir[11:8] != 4'd0)   // r0 stays zero
                    r[ir[11:8]] = wval;
            end
        end
    endfunction

    // compare process, one check per write pulse
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (expected.size() == 0) begin
                errors++;
                $display("unexpected write of %h at %0t, no value was left to expect",
                         out_data, $time);
            end else begin
                check_value(out_data, expected.pop_front(), "write value");
            end
        end
    end

    task automatic load_word(input int addr, input logic [15:0] word);
        check_value(out_valid, 0, "out_valid during load");
        check_value(halted, 0, "halted during load");
        prog_we = 1'b1;
        prog_addr = addr[ADDR_W-1:0];
        prog_wdata = word;
        @(negedge clk);
    endtask

    task automatic run_program(input string name);
        int start_errors;
        int cycles;
        start_errors = errors;
        run_reference();
        rst = 1'b1;
        writing_program = 1'b1;
        prog_we = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        foreach (code_q[i]) load_word(i, code_q[i]);
        foreach (data_q[i]) load_word(DATA_BASE + i, data_q[i]);
        prog_we = 1'b0;
        writing_program = 1'b0;       // core starts fetching at address 0
        cycles = 0;
        while (!halted && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            errors++;
            $display("timeout: test %s did not halt within %0d cycles", name, RUN_LIMIT);
        end else begin
            check_value(expected.size(), 0, "expected writes left over");
            repeat (HALT_WINDOW) begin
                @(negedge clk);
                check_value(out_valid, 0, "out_valid after halt");
                check_value(halted, 1, "halted held after halt");
            end
        end
        tests_run++;
        if (errors != start_errors)
            tests_failed++;
        $display("test %s: %s", name, (errors == start_errors) ? "ok" : "failed");
    endtask

    task automatic test_setn_write();
        code_q.delete();
        data_q.delete();
        for (int k = 1; k <= 6; k++) begin
            code_q.push_back(enc_imm(OP_SETN, 4'(k), 8'(rand16())));
            code_q.push_back(enc_imm(OP_SYS, 4'(k), {6'b0, SYS_WRITE}));
        end
        code_q.push_back(enc_imm(OP_SYS, 4'd0, {6'b0, SYS_HALT}));
        run_program("setn_write");
    endtask

    task automatic test_arith();
        code_q.delete();
        data_q.delete();
        for (int k = 0; k < 3; k++) begin
            data_q.push_back(rand16());
            data_q.push_back(rand16());
            code_q.push_back(enc_imm(OP_LOADN, 4'd1, 8'(DATA_BASE + 2 * k)));
            code_q.push_back(enc_imm(OP_LOADN, 4'd2, 8'(DATA_BASE + 2 * k + 1)));
            code_q.push_back(enc_rrr(OP_ADD, 4'd3, 4'd1, 4'd2));
            code_q.push_back(enc_rrr(OP_SUB, 4'd4, 4'd1, 4'd2));
            code_q.push_back(enc_rrr(OP_SUB, 4'd5, 4'd0, 4'd1));   // neg
            code_q.push_back(enc_rrr(OP_ADD, 4'd6, 4'd2, 4'd0));   // copy
            code_q.push_back(enc_imm(OP_ADDN, 4'd2, 8'(rand16())));
            code_q.push_back(enc_rrr(OP_ADD, 4'd0, 4'd1, 4'd2));   // r0 keeps zero
            for (int w = 0; w <= 6; w++)
                code_q.push_back(enc_imm(OP_SYS, 4'(w), {6'b0, SYS_WRITE}));
        end
        code_q.push_back(enc_imm(OP_SYS, 4'd0, {6'b0, SYS_HALT}));
        run_program("arith");
    endtask

    task automatic test_memory();
        code_q.delete();
        data_q.delete();
        data_q.push_back(rand16());
        code_q.push_back(enc_imm(OP_LOADN, 4'd1, DATA_BASE));
        code_q.push_back(enc_imm(OP_SYS, 4'd1, {6'b0, SYS_WRITE}));
        code_q.push_back(enc_imm(OP_STOREN, 4'd1, DATA_BASE + 8'd4));
        code_q.push_back(enc_imm(OP_LOADN, 4'd2, DATA_BASE + 8'd4));
        code_q.push_back(enc_imm(OP_SYS, 4'd2, {6'b0, SYS_WRITE}));
        code_q.push_back(enc_imm(OP_SETN, 4'd3, 8'(rand16())));
        code_q.push_back(enc_imm(OP_STOREN, 4'd3, DATA_BASE + 8'd5));
        code_q.push_back(enc_imm(OP_LOADN, 4'd4, DATA_BASE + 8'd5));
        code_q.push_back(enc_imm(OP_SYS, 4'd4, {6'b0, SYS_WRITE}));
        code_q.push_back(enc_imm(OP_SYS, 4'd0, {6'b0, SYS_HALT}));
        run_program("memory");
    endtask

    task automatic test_loop();
        code_q.delete();
        data_q.delete();
        code_q.push_back(enc_imm(OP_SETN, 4'd1, 8'(rand16() % 6 + 2)));
        code_q.push_back(enc_imm(OP_SETN, 4'd2, 8'd1));
        code_q.push_back(enc_imm(OP_JUMPN, 4'd0, 8'd4));              // skips address 3
        code_q.push_back(enc_imm(OP_SYS, 4'd2, {6'b0, SYS_WRITE}));
        code_q.push_back(enc_imm(OP_SYS, 4'd1, {6'b0, SYS_WRITE}));   // loop top
        code_q.push_back(enc_rrr(OP_SUB, 4'd1, 4'd1, 4'd2));
        code_q.push_back(enc_imm({OP_JCOND, COND_NEZ}, 4'd1, 8'd4));
        code_q.push_back(enc_imm(OP_SYS, 4'd0, {6'b0, SYS_HALT}));
        run_program("countdown");
    endtask

    // every condition against zero, negative and positive operands
    task automatic test_branches();
        logic [1:0] conds [4];
        logic [7:0] here;
        code_q.delete();
        data_q.delete();
        conds = '{COND_EQZ, COND_NEZ, COND_LTZ, COND_GTZ};
        data_q.push_back(16'h0000);
        data_q.push_back(rand16() | 16'h8000);
        data_q.push_back((rand16() & 16'h7fff) | 16'h0001);
        for (int c = 0; c < 4; c++) begin
            for (int v = 0; v < 3; v++) begin
                code_q.push_back(enc_imm(OP_LOADN, 4'd1, 8'(DATA_BASE + v)));
                code_q.push_back(enc_imm(OP_SETN, 4'd3, 8'(c * 16 + v)));
                here = 8'(code_q.size());
                code_q.push_back(enc_imm({OP_JCOND, conds[c]}, 4'd1, here + 8'd2));
                code_q.push_back(enc_imm(OP_SYS, 4'd3, {6'b0, SYS_WRITE})); // not taken
            end
        end
        code_q.push_back(enc_imm(OP_SYS, 4'd0, {6'b0, SYS_HALT}));
        run_program("branches");
    endtask

    initial begin
        rst = 1'b1;
        writing_program = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_wdata = '0;
        test_setn_write();
        test_arith();
        test_memory();
        test_loop();
        test_branches();
        errors += dut0.seq0.assert0.failures;
        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
verilog/cpu_pkg.sv
verilog/micro_sequencer.sv
verilog/program_counter.sv
verilog/register_file.sv
verilog/alu_unit.sv
verilog/program_memory.sv
verilog/cpu_top.sv
sim/cpu_assert.sv
sim/cpu_tb.sv
